//--- hdl/cache_pkg.sv
package cache_pkg;

  // Request and data widths
  localparam int addr_width     = 32;
  localparam int word_width     = 32;
  localparam int words_per_line = 4;
  localparam int line_width     = word_width * words_per_line;

  // Address split: tag 31..8, index 7..4, word offset 3..2
  localparam int offset_bits = 2;
  localparam int offset_lsb  = 2;
  localparam int index_bits  = 4;
  localparam int index_lsb   = offset_lsb + offset_bits;
  localparam int num_sets    = 2 ** index_bits;
  localparam int tag_lsb     = index_lsb + index_bits;
  localparam int tag_bits    = addr_width - tag_lsb;

  // Backing memory geometry, line address from bits 11..4
  localparam int mem_line_bits = 8;
  localparam int mem_lines     = 2 ** mem_line_bits;
  localparam int bytes_per_line = words_per_line * (word_width / 8);

  // Request strobe to done pulse
  localparam int mem_latency    = 4;
  localparam int mem_count_bits = 3;

  // Reset pattern: byte address XOR this key
  localparam logic [word_width-1:0] mem_init_key = 32'h5a5a_0000;

  // Controller states
  localparam logic [1:0] state_idle       = 2'b00;
  localparam logic [1:0] state_write_back = 2'b01;
  localparam logic [1:0] state_refill     = 2'b10;

endpackage

//--- hdl/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [cache_pkg::addr_width-1:0] addr,
  input  logic                            tag_fill,
  input  logic                            tag_write_hit,
  output logic                            hit,
  output logic                            victim_dirty,
  output logic [cache_pkg::tag_bits-1:0]   victim_tag
);
  import cache_pkg::*;

  logic [tag_bits-1:0]   req_tag;
  logic [index_bits-1:0] index;

  logic                valid_q [num_sets];
  logic                dirty_q [num_sets];
  logic [tag_bits-1:0] tag_q   [num_sets];

  assign req_tag = addr[tag_lsb +: tag_bits];
  assign index   = addr[index_lsb +: index_bits];

  // Lookup of the indexed set
  assign hit          = valid_q[index] && (tag_q[index] == req_tag);
  assign victim_dirty = valid_q[index] && dirty_q[index];
  assign victim_tag   = tag_q[index];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_sets; i++) begin
        valid_q[i] <= 1'b0;
        dirty_q[i] <= 1'b0;
        tag_q[i]   <= '0;
      end
    end else begin
      if (tag_fill) begin
        // New line arrives clean
        valid_q[index] <= 1'b1;
        dirty_q[index] <= 1'b0;
        tag_q[index]   <= req_tag;
      end else if (tag_write_hit) begin
        dirty_q[index] <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/cache_controller.sv
`timescale 1ns/1ps

module cache_controller (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               input_valid,
  input  logic                               mem_rw,
  input  logic [cache_pkg::addr_width-1:0]    addr,
  input  logic                               hit,
  input  logic                               victim_dirty,
  input  logic [cache_pkg::tag_bits-1:0]      victim_tag,
  input  logic                               mem_done,
  input  logic                               mem_busy,
  output logic                               ready,
  output logic                               output_valid,
  output logic                               tag_fill,
  output logic                               tag_write_hit,
  output logic                               line_fill,
  output logic                               word_write,
  output logic                               mem_req,
  output logic                               mem_write,
  output logic [cache_pkg::mem_line_bits-1:0] mem_addr
);
  import cache_pkg::*;

  logic [1:0] state;
  logic [1:0] next_state;
  logic       issued;

  logic [index_bits-1:0]    index;
  logic [mem_line_bits-1:0] victim_addr;
  logic [mem_line_bits-1:0] request_addr;

  assign index = addr[index_lsb +: index_bits];

  // Victim line rebuilt from the low stored tag bits and the index
  assign victim_addr  = {victim_tag[mem_line_bits-index_bits-1:0], index};
  assign request_addr = addr[index_lsb +: mem_line_bits];

  always_comb begin
    ready         = (state == state_idle);
    output_valid  = ready && input_valid && hit;
    word_write    = output_valid && mem_rw;
    tag_write_hit = word_write;

    // One strobe per miss state
    mem_req   = !ready && !issued && !mem_busy;
    mem_write = (state == state_write_back);
    mem_addr  = mem_write ? victim_addr : request_addr;

    line_fill = (state == state_refill) && mem_done;
    tag_fill  = line_fill;
  end

  always_comb begin
    next_state = state;
    case (state)
      state_idle: begin
        if (input_valid && !hit) begin
          next_state = victim_dirty ? state_write_back : state_refill;
        end
      end
      state_write_back: begin
        // Refill always follows the write-back
        if (mem_done) begin
          next_state = state_refill;
        end
      end
      state_refill: begin
        if (mem_done) begin
          next_state = state_idle;
        end
      end
      default: next_state = state_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= state_idle;
      issued <= 1'b0;
    end else begin
      state <= next_state;
      if (mem_done) begin
        issued <= 1'b0;
      end else if (mem_req) begin
        issued <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [cache_pkg::addr_width-1:0]  addr,
  input  logic [cache_pkg::word_width-1:0]  din,
  input  logic [cache_pkg::line_width-1:0]  mem_dout,
  input  logic                             line_fill,
  input  logic                             word_write,
  output logic [cache_pkg::word_width-1:0]  dout,
  output logic [cache_pkg::line_width-1:0]  victim_line
);
  import cache_pkg::*;

  logic [index_bits-1:0]  index;
  logic [offset_bits-1:0] offset;

  // One packed line per set, word 0 in the low bits
  logic [words_per_line-1:0][word_width-1:0] lines [num_sets];

  assign index  = addr[index_lsb +: index_bits];
  assign offset = addr[offset_lsb +: offset_bits];

  assign dout        = lines[index][offset];
  assign victim_line = lines[index];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_sets; i++) begin
        lines[i] <= '0;
      end
    end else begin
      if (line_fill) begin
        lines[index] <= mem_dout;
      end else if (word_write) begin
        // Merge the write word into the resident line
        lines[index][offset] <= din;
      end
    end
  end

endmodule

//--- hdl/backing_memory.sv
`timescale 1ns/1ps

module backing_memory (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               mem_req,
  input  logic                               mem_write,
  input  logic [cache_pkg::mem_line_bits-1:0] mem_addr,
  input  logic [cache_pkg::line_width-1:0]    mem_din,
  output logic                               mem_busy,
  output logic                               mem_done,
  output logic [cache_pkg::line_width-1:0]    mem_dout
);
  import cache_pkg::*;

  logic [words_per_line-1:0][word_width-1:0] lines [mem_lines];

  logic [mem_line_bits-1:0]  req_addr;
  logic                      req_write;
  logic [line_width-1:0]     req_data;
  logic [mem_count_bits-1:0] count;
  logic                      accept;
  logic                      finish;

  assign accept = mem_req && !mem_busy;

  // Done pulses in the cycle after the last busy one
  assign finish = mem_busy && (count == mem_count_bits'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_busy <= 1'b0;
      mem_done <= 1'b0;
      count    <= '0;
    end else begin
      mem_done <= 1'b0;
      if (accept) begin
        mem_busy <= 1'b1;
        count    <= mem_count_bits'(mem_latency - 1);
      end else if (finish) begin
        mem_busy <= 1'b0;
        mem_done <= 1'b1;
      end else if (mem_busy) begin
        count <= count - mem_count_bits'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr  <= mem_addr;
      req_write <= mem_write;
      req_data  <= mem_din;
    end
    if (finish && !req_write) begin
      mem_dout <= lines[req_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      // Every word holds its own byte address XOR the key
      for (int l = 0; l < mem_lines; l++) begin
        for (int w = 0; w < words_per_line; w++) begin
          lines[l][w] <= word_width'(l * bytes_per_line + w * 4) ^ mem_init_key;
        end
      end
    end else if (finish && req_write) begin
      lines[req_addr] <= req_data;
    end
  end

endmodule

//--- hdl/cache_top.sv
`timescale 1ns/1ps

module cache_top (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            input_valid,
  input  logic                            mem_rw,
  input  logic [cache_pkg::addr_width-1:0] addr,
  input  logic [cache_pkg::word_width-1:0] din,
  output logic                            ready,
  output logic                            hit,
  output logic                            output_valid,
  output logic [cache_pkg::word_width-1:0] dout
);
  import cache_pkg::*;

  // Lookup results
  logic                victim_dirty;
  logic [tag_bits-1:0] victim_tag;

  // Array update strobes
  logic tag_fill;
  logic tag_write_hit;
  logic line_fill;
  logic word_write;

  // Backing memory port
  logic                     mem_req;
  logic                     mem_write;
  logic [mem_line_bits-1:0] mem_addr;
  logic                     mem_busy;
  logic                     mem_done;
  logic [line_width-1:0]    mem_dout;
  logic [line_width-1:0]    victim_line;

  cache_tag_store u_tag_store (
    .clk           (clk),
    .reset         (reset),
    .addr          (addr),
    .tag_fill      (tag_fill),
    .tag_write_hit (tag_write_hit),
    .hit           (hit),
    .victim_dirty  (victim_dirty),
    .victim_tag    (victim_tag)
  );

  cache_controller u_controller (
    .clk           (clk),
    .reset         (reset),
    .input_valid   (input_valid),
    .mem_rw        (mem_rw),
    .addr          (addr),
    .hit           (hit),
    .victim_dirty  (victim_dirty),
    .victim_tag    (victim_tag),
    .mem_done      (mem_done),
    .mem_busy      (mem_busy),
    .ready         (ready),
    .output_valid  (output_valid),
    .tag_fill      (tag_fill),
    .tag_write_hit (tag_write_hit),
    .line_fill     (line_fill),
    .word_write    (word_write),
    .mem_req       (mem_req),
    .mem_write     (mem_write),
    .mem_addr      (mem_addr)
  );

  cache_data_store u_data_store (
    .clk         (clk),
    .reset       (reset),
    .addr        (addr),
    .din         (din),
    .mem_dout    (mem_dout),
    .line_fill   (line_fill),
    .word_write  (word_write),
    .dout        (dout),
    .victim_line (victim_line)
  );

  // Write-back data is the indexed line
  backing_memory u_memory (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_din   (victim_line),
    .mem_busy  (mem_busy),
    .mem_done  (mem_done),
    .mem_dout  (mem_dout)
  );

endmodule

//--- sim/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;
  import cache_pkg::*;

  logic                  clk;
  logic                  reset;
  logic                  input_valid;
  logic                  mem_rw;
  logic [addr_width-1:0] addr;
  logic [word_width-1:0] din;
  logic                  ready;
  logic                  hit;
  logic                  output_valid;
  logic [word_width-1:0] dout;

  // Requests as read from the input file
  logic [7:0]            req_op   [$];
  logic [addr_width-1:0] req_addr [$];
  logic [word_width-1:0] req_data [$];

  // Reference words, keyed by word index inside the 4 KiB backing space
  logic [word_width-1:0] word_model [int];

  // Expected cache contents per set
  logic                model_valid [num_sets];
  logic                model_dirty [num_sets];
  logic [tag_bits-1:0] model_tag   [num_sets];

  int checks = 0;
  int value_errors = 0;
  int other_errors = 0;
  int cycle_count = 0;
  int cycle_limit = 0;
  int fd;

  cache_top u_dut (
    .clk          (clk),
    .reset        (reset),
    .input_valid  (input_valid),
    .mem_rw       (mem_rw),
    .addr         (addr),
    .din          (din),
    .ready        (ready),
    .hit          (hit),
    .output_valid (output_valid),
    .dout         (dout)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the requests did not finish within %0d cycles", cycle_limit);
      $display("Checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
      $display("test failed");
      $finish;
    end
  end

  task automatic load_requests();
    string                 line;
    logic [7:0]            op;
    logic [addr_width-1:0] a;
    logic [word_width-1:0] d;
    int                    n;
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // Comment lines start with a hash, blank lines fail the scan
      if (n > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%c %h %h", op, a, d);
        if (n == 3) begin
          req_op.push_back(op);
          req_addr.push_back(a);
          req_data.push_back(d);
        end
      end
    end
    $fclose(fd);
  endtask

  // Backing memory wraps at 4 KiB, so only bits 11..2 name a word
  function automatic logic [word_width-1:0] model_read(input logic [addr_width-1:0] a);
    if (word_model.exists(int'(a[11:2]))) begin
      return word_model[int'(a[11:2])];
    end
    return {20'h0, a[11:2], 2'b00} ^ mem_init_key;
  endfunction

  // Cycles with ready low: none on a hit, one memory access or two
  function automatic int predict_low_cycles(input logic [addr_width-1:0] a);
    logic [index_bits-1:0] set;
    set = a[index_lsb +: index_bits];
    if (model_valid[set] && model_tag[set] == a[tag_lsb +: tag_bits]) begin
      return 0;
    end else if (model_valid[set] && model_dirty[set]) begin
      return 2 * (mem_latency + 1);
    end
    return mem_latency + 1;
  endfunction

  task automatic check_idle_after_reset();
    repeat (3) begin
      @(negedge clk);
      checks++;
      if (ready !== 1'b1) begin
        $display("Fail ready after reset: expected %h, got %h", 1'b1, ready);
        value_errors++;
      end
      if (output_valid !== 1'b0) begin
        $display("Fail output_valid after reset: expected %h, got %h", 1'b0, output_valid);
        value_errors++;
      end
      if (hit !== 1'b0) begin
        $display("Fail hit after reset: expected %h, got %h", 1'b0, hit);
        value_errors++;
      end
      if (u_dut.mem_req !== 1'b0) begin
        $display("Fail mem_req after reset: expected %h, got %h", 1'b0, u_dut.mem_req);
        value_errors++;
      end
    end
  endtask

  task automatic run_request(input logic [7:0] op, input logic [addr_width-1:0] a,
                             input logic [word_width-1:0] d);
    logic                  is_write;
    logic                  done;
    logic [word_width-1:0] expected;
    logic [index_bits-1:0] set;
    int                    expected_low;
    int                    expected_cycles;
    int                    cycles;
    int                    low_cycles;
    is_write = (op == "W");
    expected = model_read(a);
    expected_low = predict_low_cycles(a);
    expected_cycles = (expected_low == 0) ? 1 : expected_low + 2;
    set = a[index_lsb +: index_bits];

    @(posedge clk);
    input_valid <= 1'b1;
    mem_rw      <= is_write;
    addr        <= a;
    din         <= is_write ? d : '0;

    // Request held until the cache answers
    cycles = 0;
    low_cycles = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (!ready) begin
        low_cycles++;
      end
      if (output_valid) begin
        done = 1'b1;
      end
    end

    checks++;
    if (hit !== 1'b1) begin
      $display("Fail hit at %h: expected %h, got %h", a, 1'b1, hit);
      value_errors++;
    end
    if (low_cycles != expected_low) begin
      $display("Fail ready low cycles at %h: expected %h, got %h", a, expected_low, low_cycles);
      value_errors++;
    end
    if (cycles != expected_cycles) begin
      $display("Fail output_valid cycle at %h: expected %h, got %h", a, expected_cycles, cycles);
      value_errors++;
    end
    if (!is_write) begin
      if (dout !== expected) begin
        $display("Fail dout at %h: expected %h, got %h", a, expected, dout);
        value_errors++;
      end
      if (d !== expected) begin
        $display("The input file expects %h at %h but the reference model holds %h",
                 d, a, expected);
        other_errors++;
      end
    end

    if (is_write) begin
      word_model[int'(a[11:2])] = d;
    end
    if (expected_low != 0) begin
      model_dirty[set] = 1'b0;
    end
    model_valid[set] = 1'b1;
    model_tag[set] = a[tag_lsb +: tag_bits];
    if (is_write) begin
      model_dirty[set] = 1'b1;
    end
  endtask

  initial begin
    reset = 1'b1;
    input_valid = 1'b0;
    mem_rw = 1'b0;
    addr = '0;
    din = '0;
    for (int s = 0; s < num_sets; s++) begin
      model_valid[s] = 1'b0;
      model_dirty[s] = 1'b0;
      model_tag[s] = '0;
    end

    fd = $fopen("sim/cache_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the request file sim/cache_input.txt");
      $display("Checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
      $display("test failed");
      $finish;
    end else begin
      load_requests();
      if (req_op.size() == 0) begin
        $display("The request file holds no requests");
        other_errors++;
      end
      // Worst case is a dirty miss of 12 cycles per request
      cycle_limit = req_op.size() * 12 + 50;

      repeat (8) @(posedge clk);
      reset <= 1'b0;
      check_idle_after_reset();

      for (int i = 0; i < req_op.size(); i++) begin
        run_request(req_op[i], req_addr[i], req_data[i]);
      end
      @(posedge clk);
      input_valid <= 1'b0;
      @(negedge clk);

      $display("Checks %0d, value errors %0d, other errors %0d",
               checks, value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule

//--- sim/cache_input.txt
# op (R read, W write), hex address, hex data
# data is the write word for W and the expected read word for R
R 00000100 5a5a0100
R 00000104 5a5a0104
W 00000108 11112222
R 00000108 11112222
R 00000200 5a5a0200
R 00000108 11112222
R 0000010c 5a5a010c
W 00000234 a5a5f00d
R 00000234 a5a5f00d
W 00001230 0badcafe
R 00001234 a5a5f00d
R 00000230 0badcafe
R 00000ff0 5a5a0ff0
W 00000ffc 12345678
R 0000fffc 12345678
R 00000ff4 5a5a0ff4
W 00000040 cafe0001
W 00000044 cafe0002
R 00000040 cafe0001
R 00000540 5a5a0540
R 00000044 cafe0002
R 00000100 5a5a0100
W 00000500 77778888
R 00001500 77778888

//--- compile.f
hdl/cache_pkg.sv
hdl/cache_tag_store.sv
hdl/cache_controller.sv
hdl/cache_data_store.sv
hdl/backing_memory.sv
hdl/cache_top.sv
sim/cache_tb.sv

//--- Makefile
TOP = cache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
